// File: rtl/fifo_cfg_pkg.sv
`default_nettype none

package fifo_cfg_pkg;

  // Storage geometry
  localparam int unsigned fifo_depth = 16;                  // Power of two only
  localparam int unsigned addr_width = $clog2(fifo_depth);
  localparam int unsigned data_width = 8;

  // Almost-full is taken in the write domain, at or above this level
  localparam int unsigned afull_level = 14;

  // Almost-empty is taken in the read domain, at or below this level
  localparam int unsigned aempty_level = 1;

endpackage

`default_nettype wire

// File: rtl/fifo_types_pkg.sv
`default_nettype none

package fifo_types_pkg;

  // One stored word
  typedef logic [fifo_cfg_pkg::data_width-1:0] data_t;

  // Index into the RAM
  typedef logic [fifo_cfg_pkg::addr_width-1:0] addr_t;

  // Pointer with a wrap bit above the address.
  // The same type carries both the binary and the Gray form.
  typedef logic [fifo_cfg_pkg::addr_width:0] ptr_t;

endpackage

`default_nettype wire

// File: rtl/dualport_ram_async.sv
`timescale 1ns/1ps
`default_nettype none

module dualport_ram_async (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  fifo_types_pkg::addr_t wr_addr,
  input  fifo_types_pkg::data_t wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  input  fifo_types_pkg::addr_t rd_addr,
  output fifo_types_pkg::data_t rd_data
);

  fifo_types_pkg::data_t mem [fifo_cfg_pkg::fifo_depth];

  // Write port
  always_ff @(posedge wr_clk) begin
    if (wr_en && wr_rst_n) begin // Hold off while in reset
      mem[wr_addr] <= wr_data;
    end
  end

  // Read port, output register cleared on read reset
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr]; // Holds until next read
    end
  end

endmodule

`default_nettype wire

// File: rtl/ptr_sync.sv
`timescale 1ns/1ps
`default_nettype none

module ptr_sync (
  input  logic                 clk,
  input  logic                 rst_n,
  input  fifo_types_pkg::ptr_t gray_in,
  output fifo_types_pkg::ptr_t bin_out
);

  localparam int unsigned ptr_width = fifo_cfg_pkg::addr_width + 1;

  fifo_types_pkg::ptr_t gray_meta; // First stage, may go metastable
  fifo_types_pkg::ptr_t gray_sync;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gray_meta <= '0;
      gray_sync <= '0;
    end else begin
      gray_meta <= gray_in;
      gray_sync <= gray_meta;
    end
  end

  // Gray to binary, each bit is the XOR of all Gray bits at and above it
  for (genvar i = 0; i < ptr_width; i++) begin : g_bin
    assign bin_out[i] = ^gray_sync[ptr_width-1:i];
  end

endmodule

`default_nettype wire

// File: rtl/wr_ptr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module wr_ptr_ctrl (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  fifo_types_pkg::ptr_t  rd_ptr_wsync,
  output logic                  wr_vld,
  output fifo_types_pkg::addr_t wr_addr,
  output fifo_types_pkg::ptr_t  wr_gray,
  output logic                  full,
  output logic                  afull
);

  fifo_types_pkg::ptr_t wr_ptr;
  fifo_types_pkg::ptr_t wr_ptr_nxt;
  fifo_types_pkg::ptr_t wr_gray_nxt;
  fifo_types_pkg::ptr_t wr_used_nxt;

  // Accepted write
  assign wr_vld = wr_en && !full;

  always_comb begin
    if (wr_vld) begin
      wr_ptr_nxt = wr_ptr + 1'b1;
    end else begin
      wr_ptr_nxt = wr_ptr;
    end
  end

  assign wr_gray_nxt = wr_ptr_nxt ^ (wr_ptr_nxt >> 1);

  // Occupancy as seen from the write side, wrap bit keeps 0..depth apart
  assign wr_used_nxt = wr_ptr_nxt - rd_ptr_wsync;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr  <= '0;
      wr_gray <= '0;
    end else begin
      wr_ptr  <= wr_ptr_nxt;
      wr_gray <= wr_gray_nxt; // Only registered Gray leaves the domain
    end
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= (wr_used_nxt == fifo_types_pkg::ptr_t'(fifo_cfg_pkg::fifo_depth));
      afull <= (wr_used_nxt >= fifo_types_pkg::ptr_t'(fifo_cfg_pkg::afull_level));
    end
  end

  assign wr_addr = wr_ptr[fifo_cfg_pkg::addr_width-1:0]; // Drop wrap bit

endmodule

`default_nettype wire

// File: rtl/rd_ptr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rd_ptr_ctrl (
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  input  fifo_types_pkg::ptr_t  wr_ptr_rsync,
  output logic                  rd_vld,
  output fifo_types_pkg::addr_t rd_addr,
  output fifo_types_pkg::ptr_t  rd_gray,
  output logic                  empty,
  output logic                  aempty
);

  fifo_types_pkg::ptr_t rd_ptr;
  fifo_types_pkg::ptr_t rd_ptr_nxt;
  fifo_types_pkg::ptr_t rd_gray_nxt;
  fifo_types_pkg::ptr_t rd_used_nxt;

  // Accepted read
  assign rd_vld = rd_en && !empty;

  always_comb begin
    if (rd_vld) begin
      rd_ptr_nxt = rd_ptr + 1'b1;
    end else begin
      rd_ptr_nxt = rd_ptr;
    end
  end

  assign rd_gray_nxt = rd_ptr_nxt ^ (rd_ptr_nxt >> 1);

  // Words left after this edge, per the synchronized write pointer
  assign rd_used_nxt = wr_ptr_rsync - rd_ptr_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr  <= '0;
      rd_gray <= '0;
    end else begin
      rd_ptr  <= rd_ptr_nxt;
      rd_gray <= rd_gray_nxt;
    end
  end

  // Both flags come up set out of reset
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= (rd_ptr_nxt == wr_ptr_rsync);
      aempty <= (rd_used_nxt <= fifo_types_pkg::ptr_t'(fifo_cfg_pkg::aempty_level));
    end
  end

  assign rd_addr = rd_ptr[fifo_cfg_pkg::addr_width-1:0];

endmodule

`default_nettype wire

// File: rtl/async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  fifo_types_pkg::data_t wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  output fifo_types_pkg::data_t rd_data,
  output logic                  full,
  output logic                  afull,
  output logic                  empty,
  output logic                  aempty
);

  // Write domain
  logic                  wr_vld;
  fifo_types_pkg::addr_t wr_addr;
  fifo_types_pkg::ptr_t  wr_gray;
  fifo_types_pkg::ptr_t  rd_ptr_wsync;

  // Read domain
  logic                  rd_vld;
  fifo_types_pkg::addr_t rd_addr;
  fifo_types_pkg::ptr_t  rd_gray;
  fifo_types_pkg::ptr_t  wr_ptr_rsync;

  wr_ptr_ctrl i_wr_ptr_ctrl (
    .wr_clk       (wr_clk),
    .wr_rst_n     (wr_rst_n),
    .wr_en        (wr_en),
    .rd_ptr_wsync (rd_ptr_wsync),
    .wr_vld       (wr_vld),
    .wr_addr      (wr_addr),
    .wr_gray      (wr_gray),
    .full         (full),
    .afull        (afull)
  );

  rd_ptr_ctrl i_rd_ptr_ctrl (
    .rd_clk       (rd_clk),
    .rd_rst_n     (rd_rst_n),
    .rd_en        (rd_en),
    .wr_ptr_rsync (wr_ptr_rsync),
    .rd_vld       (rd_vld),
    .rd_addr      (rd_addr),
    .rd_gray      (rd_gray),
    .empty        (empty),
    .aempty       (aempty)
  );

  // Write pointer into the read domain
  ptr_sync i_wr_ptr_sync (
    .clk     (rd_clk),
    .rst_n   (rd_rst_n),
    .gray_in (wr_gray),
    .bin_out (wr_ptr_rsync)
  );

  // Read pointer into the write domain
  ptr_sync i_rd_ptr_sync (
    .clk     (wr_clk),
    .rst_n   (wr_rst_n),
    .gray_in (rd_gray),
    .bin_out (rd_ptr_wsync)
  );

  dualport_ram_async i_dualport_ram_async (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_vld),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_vld),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

endmodule

`default_nettype wire

// File: tests/async_fifo_assert.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo_assert (
  input logic                 wr_clk,
  input logic                 wr_rst_n,
  input logic                 rd_clk,
  input logic                 rd_rst_n,
  input fifo_types_pkg::ptr_t wr_gray,
  input fifo_types_pkg::ptr_t rd_gray,
  input logic                 wr_vld,
  input logic                 rd_vld
);

  fifo_types_pkg::ptr_t occ_live;

  function automatic fifo_types_pkg::ptr_t gray_to_bin(input fifo_types_pkg::ptr_t g);
    fifo_types_pkg::ptr_t b;
    b[fifo_cfg_pkg::addr_width] = g[fifo_cfg_pkg::addr_width];
    for (int i = int'(fifo_cfg_pkg::addr_width) - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // Occupancy from both live pointers, not the synchronized copies
  assign occ_live = gray_to_bin(wr_gray) - gray_to_bin(rd_gray);

  // One bit per edge keeps the crossing safe
  a_wr_gray_step: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    $countones(wr_gray ^ $past(wr_gray)) <= 1)
    else $error("wr_gray changed by more than one bit");

  a_rd_gray_step: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    $countones(rd_gray ^ $past(rd_gray)) <= 1)
    else $error("rd_gray changed by more than one bit");

  a_no_write_full: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    wr_vld |-> occ_live < fifo_types_pkg::ptr_t'(fifo_cfg_pkg::fifo_depth))
    else $error("RAM write while full");

  a_no_read_empty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    rd_vld |-> occ_live != '0)
    else $error("RAM read while empty");

endmodule

bind async_fifo async_fifo_assert i_async_fifo_assert (
  .wr_clk   (wr_clk),
  .wr_rst_n (wr_rst_n),
  .rd_clk   (rd_clk),
  .rd_rst_n (rd_rst_n),
  .wr_gray  (wr_gray),
  .rd_gray  (rd_gray),
  .wr_vld   (wr_vld),
  .rd_vld   (rd_vld)
);

`default_nettype wire

// File: tests/async_fifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo_tb;

  localparam int rd_half_period = 3;
  localparam int rd_pat_len     = 300;

  logic                  wr_clk;
  logic                  wr_rst_n;
  logic                  wr_en;
  fifo_types_pkg::data_t wr_data;
  logic                  rd_clk;
  logic                  rd_rst_n;
  logic                  rd_en;
  fifo_types_pkg::data_t rd_data;
  logic                  full;
  logic                  afull;
  logic                  empty;
  logic                  aempty;

  integer                seed;
  int                    rnd;
  fifo_types_pkg::data_t ref_q [$]; // Words written, oldest first
  logic                  rd_pend;   // Read accepted on the previous rd_clk edge
  logic                  wr_stop;
  bit                    rd_pat [rd_pat_len];

  async_fifo i_async_fifo (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  always #2 wr_clk = ~wr_clk;
  always #rd_half_period rd_clk = ~rd_clk;

  // Expected {full, afull, empty, aempty} for a given occupancy
  function automatic logic [3:0] flags_for(input int unsigned occ);
    logic [3:0] f;
    f[3] = (occ == fifo_cfg_pkg::fifo_depth);
    f[2] = (occ >= fifo_cfg_pkg::afull_level);
    f[1] = (occ == 0);
    f[0] = (occ <= fifo_cfg_pkg::aempty_level);
    return f;
  endfunction

  function automatic logic [3:0] dut_flags();
    return {full, afull, empty, aempty};
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("FAIL %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "Simulation stopped");
    end
  endtask

  task automatic write_words(input int n);
    int acc;
    int cycles;
    acc = 0;
    cycles = 0;
    @(posedge wr_clk);
    rnd = $random(seed);
    wr_en   <= 1'b1;
    wr_data <= fifo_types_pkg::data_t'(rnd);
    while (acc < n) begin
      @(posedge wr_clk);
      cycles++;
      if (wr_en && !full) begin
        acc++;
      end
      if (acc == n) begin
        wr_en <= 1'b0;
      end else begin
        rnd = $random(seed);
        wr_data <= fifo_types_pkg::data_t'(rnd);
      end
      if (cycles > 4 * n + 40) begin
        abort_run("Timeout while writing words into the FIFO");
      end
    end
  endtask

  task automatic read_words(input int n);
    int acc;
    int cycles;
    acc = 0;
    cycles = 0;
    @(posedge rd_clk);
    rd_en <= 1'b1;
    while (acc < n) begin
      @(posedge rd_clk);
      cycles++;
      if (rd_en && !empty) begin
        acc++;
      end
      if (acc == n) begin
        rd_en <= 1'b0;
      end
      if (cycles > 4 * n + 40) begin
        abort_run("Timeout while reading words from the FIFO");
      end
    end
  endtask

  // Writes until full is seen, returns the accepted count
  task automatic fill_to_full(output int acc);
    int cycles;
    acc = 0;
    cycles = 0;
    @(posedge wr_clk);
    rnd = $random(seed);
    wr_en   <= 1'b1;
    wr_data <= fifo_types_pkg::data_t'(rnd);
    while (!full) begin
      @(posedge wr_clk);
      cycles++;
      if (wr_en && !full) begin
        acc++;
      end
      rnd = $random(seed);
      wr_data <= fifo_types_pkg::data_t'(rnd);
      if (cycles > 100) begin
        abort_run("Timeout while waiting for full to rise");
      end
    end
    wr_en <= 1'b0;
  endtask

  // Flags unchanged for 8 read cycles
  task automatic settle_flags();
    logic [3:0] last;
    int         stable;
    int         cycles;
    last = dut_flags();
    stable = 0;
    cycles = 0;
    while (stable < 8) begin
      @(posedge rd_clk);
      cycles++;
      if (dut_flags() == last) begin
        stable++;
      end else begin
        stable = 0;
        last = dut_flags();
      end
      if (cycles > 60) begin
        abort_run("Timeout while waiting for the flags to settle");
      end
    end
  endtask

  task automatic drain_all();
    int stable;
    int cycles;
    stable = 0;
    cycles = 0;
    @(posedge rd_clk);
    rd_en <= 1'b1;
    while (stable < 8) begin
      @(posedge rd_clk);
      cycles++;
      if (empty) begin
        stable++;
      end else begin
        stable = 0;
      end
      if (cycles > 300) begin
        abort_run("Timeout while draining the FIFO");
      end
    end
    rd_en <= 1'b0;
    repeat (2) @(posedge rd_clk); // Last pending word gets compared
  endtask

  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_en && !full) begin
      ref_q.push_back(wr_data);
    end
  end

  // Read data shows up one rd_clk cycle after the accepting edge
  always @(posedge rd_clk) begin
    if (rd_pend) begin
      if (ref_q.size() == 0) begin
        abort_run("Read returned a word that was never written");
      end
      check_val(32'(rd_data), 32'(ref_q.pop_front()), "read data");
      rd_pend = 1'b0;
    end
    if (rd_rst_n && rd_en && !empty) begin
      rd_pend = 1'b1;
    end
  end

  initial begin
    int                    acc;
    int                    ks [4];
    int                    rd_idx;
    fifo_types_pkg::data_t held;
    seed      = 32'ha4ff;
    wr_clk    = 1'b0;
    rd_clk    = 1'b0;
    wr_rst_n  = 1'b0;
    rd_rst_n  = 1'b0;
    wr_en     = 1'b0;
    rd_en     = 1'b0;
    wr_data   = '0;
    rd_pend   = 1'b0;
    wr_stop   = 1'b0;
    repeat (3) @(posedge wr_clk);
    wr_rst_n <= 1'b1;
    rd_rst_n <= 1'b1;

    @(posedge rd_clk);
    check_val(32'(dut_flags()), 32'(flags_for(0)), "flags after reset");
    check_val(32'(rd_data), 32'h0, "rd_data after reset");

    fill_to_full(acc);
    check_val(32'(acc), 32'(fifo_cfg_pkg::fifo_depth), "writes accepted before full");
    settle_flags();
    check_val(32'(dut_flags()), 32'(flags_for(fifo_cfg_pkg::fifo_depth)), "flags when full");

    // Writes under full must not land
    @(posedge wr_clk);
    wr_en <= 1'b1;
    repeat (6) begin
      @(posedge wr_clk);
      rnd = $random(seed);
      wr_data <= fifo_types_pkg::data_t'(rnd);
    end
    wr_en <= 1'b0;
    @(posedge wr_clk);
    check_val(32'(ref_q.size()), 32'(fifo_cfg_pkg::fifo_depth), "words queued while full");
    read_words(int'(fifo_cfg_pkg::fifo_depth));
    settle_flags();
    check_val(32'(dut_flags()), 32'(flags_for(0)), "flags after drain");
    check_val(32'(ref_q.size()), 32'h0, "words left after drain");

    ks = '{1, int'(fifo_cfg_pkg::aempty_level) + 1, int'(fifo_cfg_pkg::afull_level) - 1,
           int'(fifo_cfg_pkg::afull_level)};
    foreach (ks[i]) begin
      write_words(ks[i]);
      settle_flags();
      check_val(32'(dut_flags()), 32'(flags_for(ks[i])), $sformatf("flags at %0d words", ks[i]));
      read_words(ks[i]);
      settle_flags();
      check_val(32'(dut_flags()), 32'(flags_for(0)), "flags after partial drain");
    end

    for (int i = 0; i < rd_pat_len; i++) begin
      rnd = $random(seed);
      rd_pat[i] = rnd[0];
    end
    fork
      begin
        repeat (400) begin
          @(posedge wr_clk);
          rnd = $random(seed);
          wr_en   <= (rnd[1:0] != 2'b00);
          wr_data <= fifo_types_pkg::data_t'(rnd >> 8);
        end
        @(posedge wr_clk);
        wr_en <= 1'b0;
        wr_stop = 1'b1;
      end
      begin
        rd_idx = 0;
        while (!wr_stop) begin
          @(posedge rd_clk);
          rd_en <= rd_pat[rd_idx % rd_pat_len];
          rd_idx++;
          if (rd_idx > 1000) begin
            abort_run("Timeout in the concurrent read process");
          end
        end
        rd_en <= 1'b0;
      end
    join
    drain_all();
    check_val(32'(ref_q.size()), 32'h0, "words left after random traffic");

    // Reads under empty
    held = rd_data;
    @(posedge rd_clk);
    rd_en <= 1'b1;
    repeat (8) begin
      @(posedge rd_clk);
      check_val(32'(rd_data), 32'(held), "rd_data during read under empty");
      check_val(32'(empty), 32'h1, "empty during read under empty");
    end
    rd_en <= 1'b0;
    @(posedge rd_clk);
    check_val(32'(rd_data), 32'(held), "rd_data after read under empty");

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: async_fifo.f
rtl/fifo_cfg_pkg.sv
rtl/fifo_types_pkg.sv
rtl/dualport_ram_async.sv
rtl/ptr_sync.sv
rtl/wr_ptr_ctrl.sv
rtl/rd_ptr_ctrl.sv
rtl/async_fifo.sv
tests/async_fifo_assert.sv
tests/async_fifo_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the async FIFO testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
    --top-module async_fifo_tb -Mdir obj_dir -f async_fifo.f; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/Vasync_fifo_tb)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qF 'All tests passed!'; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi
